// File: tb.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/inst_mem.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/fetch_unit.sv
source/rv_core_top.sv
tests/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rv64 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module rv_core_tb -o rv_core_sim

# the simulator exits non-zero on a fatal check, so keep its output either way
sim_out="$(./obj_dir/rv_core_sim 2>&1 || true)"
echo "$sim_out"

if grep -qx "Simulation completed successfully" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// File: tests/rv_core_tb.sv
/*
  rv64 core testbench
  directed programs checked cycle by cycle against a reference model
*/
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_tb;

  // upper bound on instructions per program run
  localparam int CYCLE_LIMIT = 2000;

  logic                  clk;
  logic                  arst_n;
  logic                  run;
  logic                  load_en;
  logic [7:0]            load_addr;
  logic [`INST_W-1:0]    load_data;
  logic                  retire_valid;
  logic [`XLEN-1:0]      retire_pc;
  logic [`REG_IDX_W-1:0] retire_rd;
  logic                  retire_wen;
  logic [`XLEN-1:0]      retire_data;
  logic                  halted;
  rv_ctrl_pkg::trap_e    trap_cause;

  // reference model state
  logic [`XLEN-1:0]   m_regs [32];
  logic [`XLEN-1:0]   m_pc;
  logic [`INST_W-1:0] image [`IMEM_DEPTH];
  // program being assembled
  logic [`INST_W-1:0] prog [$];
  logic [31:0]        lfsr;

  rv_core_top dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .run          (run),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_data  (retire_data),
    .halted       (halted),
    .trap_cause   (trap_cause)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first failing check");
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  // assemblers, all through the instruction views
  function automatic void emit_i(rv_isa_pkg::opcode_e op, int f3, int rd, int rs1, int imm);
    rv_isa_pkg::inst_u w;
    w = '0;
    w.i_fmt.imm12  = 12'(imm);
    w.i_fmt.rs1    = 5'(rs1);
    w.i_fmt.funct3 = 3'(f3);
    w.i_fmt.rd     = 5'(rd);
    w.i_fmt.opcode = op;
    prog.push_back(w);
  endfunction

  function automatic void emit_addi(int rd, int rs1, int imm);
    emit_i(rv_isa_pkg::op_imm, 0, rd, rs1, imm);
  endfunction

  // ebreak is system with imm 1
  function automatic void emit_ebreak();
    emit_i(rv_isa_pkg::system, 0, 0, 0, 1);
  endfunction

  // funct7 0 add, 32 sub
  function automatic void emit_alu(int f7, int rd, int rs1, int rs2);
    rv_isa_pkg::inst_u w;
    w = '0;
    w.r_fmt.funct7 = 7'(f7);
    w.r_fmt.rs2    = 5'(rs2);
    w.r_fmt.rs1    = 5'(rs1);
    w.r_fmt.rd     = 5'(rd);
    w.r_fmt.opcode = rv_isa_pkg::op;
    prog.push_back(w);
  endfunction

  function automatic void emit_upper(rv_isa_pkg::opcode_e op, int rd, int imm20);
    rv_isa_pkg::inst_u w;
    w = '0;
    w.u_fmt.imm20  = 20'(imm20);
    w.u_fmt.rd     = 5'(rd);
    w.u_fmt.opcode = op;
    prog.push_back(w);
  endfunction

  // byte offset, scrambled as imm[20|10:1|11|19:12]
  function automatic void emit_jal(int rd, int off);
    rv_isa_pkg::inst_u w;
    logic [20:0]       o;
    o = 21'(off);
    w = '0;
    w.j_fmt.imm20  = {o[20], o[10:1], o[11], o[19:12]};
    w.j_fmt.rd     = 5'(rd);
    w.j_fmt.opcode = rv_isa_pkg::jal;
    prog.push_back(w);
  endfunction

  // expected effect of the word at the model pc
  task automatic model_eval(output logic [`XLEN-1:0] data, output logic [`XLEN-1:0] next_pc,
                            output logic [`REG_IDX_W-1:0] rd, output logic wen,
                            output rv_ctrl_pkg::trap_e cause);
    rv_isa_pkg::inst_u w;
    logic [`XLEN-1:0]  src_1;
    logic [`XLEN-1:0]  src_2;
    logic [`XLEN-1:0]  u_imm;
    logic [`XLEN-1:0]  j_imm;
    w       = image[m_pc[9:2]];
    src_1   = m_regs[w.r_fmt.rs1];
    src_2   = m_regs[w.r_fmt.rs2];
    u_imm   = {{32{w[31]}}, w[31:12], 12'h000};
    j_imm   = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    rd      = w.r_fmt.rd;
    data    = '0;
    next_pc = m_pc + 64'd4;
    wen     = 1'b1;
    cause   = rv_ctrl_pkg::trap_none;
    case (w.r_fmt.opcode)
      rv_isa_pkg::op_imm: begin
        data = src_1 + {{52{w[31]}}, w[31:20]};
        if (w.i_fmt.funct3 != 3'b000) begin
          cause = rv_ctrl_pkg::trap_illegal;
        end
      end
      rv_isa_pkg::op: begin
        if (w.r_fmt.funct3 == 3'b000 && w.r_fmt.funct7 == 7'h00) begin
          data = src_1 + src_2;
        end else if (w.r_fmt.funct3 == 3'b000 && w.r_fmt.funct7 == 7'h20) begin
          data = src_1 - src_2;
        end else begin
          cause = rv_ctrl_pkg::trap_illegal;
        end
      end
      rv_isa_pkg::lui:   data = u_imm;
      rv_isa_pkg::auipc: data = m_pc + u_imm;
      rv_isa_pkg::jal: begin
        data    = m_pc + 64'd4;
        next_pc = m_pc + j_imm;
      end
      rv_isa_pkg::system: begin
        cause = (w == 32'h0010_0073) ? rv_ctrl_pkg::trap_ebreak : rv_ctrl_pkg::trap_illegal;
      end
      default: cause = rv_ctrl_pkg::trap_illegal;
    endcase
    // no write for x0 or a trapping word
    if (cause != rv_ctrl_pkg::trap_none || rd == '0) begin
      wen = 1'b0;
    end
  endtask

  task automatic reset_core();
    @(posedge clk);
    arst_n  <= 1'b0;
    run     <= 1'b0;
    load_en <= 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = `RST_PC;
  endtask

  // loads while run is low, mirrors words into the model image
  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= 8'(i);
      load_data <= prog[i];
      image[i] = prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // one cycle, sampled mid cycle, model updated at the commit edge
  task automatic check_step(output logic trapped);
    logic [`XLEN-1:0]      data;
    logic [`XLEN-1:0]      next_pc;
    logic [`REG_IDX_W-1:0] rd;
    logic                  wen;
    rv_ctrl_pkg::trap_e    cause;
    @(negedge clk);
    model_eval(data, next_pc, rd, wen, cause);
    trapped = (cause != rv_ctrl_pkg::trap_none);
    if (!trapped) begin
      check_value("retire_valid", 64'(retire_valid), 64'd1);
      check_value("retire_pc", retire_pc, m_pc);
      check_value("retire_rd", 64'(retire_rd), 64'(rd));
      check_value("retire_wen", 64'(retire_wen), 64'(wen));
      if (wen) begin
        check_value("retire_data", retire_data, data);
      end
    end else begin
      // trapping word never retires
      check_value("retire_valid", 64'(retire_valid), 64'd0);
    end
    @(posedge clk);
    if (!trapped) begin
      if (wen) begin
        m_regs[rd] = data;
      end
      m_pc = next_pc;
    end
  endtask

  // called right after a commit edge
  task automatic stall_core(int n);
    run <= 1'b0;
    repeat (n) begin
      @(negedge clk);
      check_value("retire_valid", 64'(retire_valid), 64'd0);
      check_value("retire_pc", retire_pc, m_pc);
      @(posedge clk);
    end
    run <= 1'b1;
  endtask

  task automatic run_to_halt(rv_ctrl_pkg::trap_e exp_cause, int stall_at, int stall_len);
    int   cycles;
    logic trapped;
    @(posedge clk);
    run <= 1'b1;
    cycles  = 0;
    trapped = 1'b0;
    while (!trapped) begin
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout: core still running after %0d cycles", CYCLE_LIMIT);
        abort_run();
      end
      check_step(trapped);
      cycles++;
      if (!trapped && cycles == stall_at) begin
        stall_core(stall_len);
      end
    end
    // halt latched at the trapping edge, pc frozen
    @(negedge clk);
    check_value("halted", 64'(halted), 64'd1);
    check_value("trap_cause", 64'(trap_cause), 64'(exp_cause));
    repeat (20) begin
      check_value("retire_valid", 64'(retire_valid), 64'd0);
      check_value("retire_pc", retire_pc, m_pc);
      @(negedge clk);
    end
    @(posedge clk);
    run <= 1'b0;
  endtask

  // random chain over x0..x7, x0 included on purpose
  function automatic void emit_random_chain(int n);
    int rd;
    int rs1;
    int rs2;
    for (int i = 0; i < n; i++) begin
      rd  = int'(rand_bits(3));
      rs1 = int'(rand_bits(3));
      rs2 = int'(rand_bits(3));
      case (int'(rand_bits(2)))
        0, 1:    emit_addi(rd, rs1, int'(rand_bits(12)));
        2:       emit_alu(0, rd, rs1, rs2);
        default: emit_alu(32, rd, rs1, rs2);
      endcase
    end
  endfunction

  task automatic test_reset_state();
    reset_core();
    prog.delete();
    emit_addi(1, 0, 5);
    emit_ebreak();
    load_program();
    // idle core after reset
    @(negedge clk);
    check_value("retire_valid", 64'(retire_valid), 64'd0);
    check_value("halted", 64'(halted), 64'd0);
    check_value("trap_cause", 64'(trap_cause), 64'(rv_ctrl_pkg::trap_none));
    check_value("retire_pc", retire_pc, `RST_PC);
    run_to_halt(rv_ctrl_pkg::trap_ebreak, -1, 0);
  endtask

  task automatic test_arith();
    reset_core();
    prog.delete();
    emit_addi(1, 0, int'(rand_bits(12)));
    emit_addi(2, 0, int'(rand_bits(12)));
    emit_random_chain(24);
    // x0 write is dropped, then x0 reads back zero
    emit_addi(0, 1, 2047);
    emit_alu(0, 3, 0, 0);
    emit_alu(32, 4, 0, 2);
    emit_ebreak();
    load_program();
    run_to_halt(rv_ctrl_pkg::trap_ebreak, -1, 0);
  endtask

  task automatic test_upper();
    reset_core();
    prog.delete();
    emit_upper(rv_isa_pkg::lui, 5, int'(rand_bits(19)) | 32'h8_0000);
    emit_upper(rv_isa_pkg::lui, 6, int'(rand_bits(19)));
    emit_upper(rv_isa_pkg::auipc, 7, int'(rand_bits(20)));
    emit_addi(8, 7, 1);
    emit_upper(rv_isa_pkg::auipc, 9, 32'hf_ffff);
    emit_ebreak();
    load_program();
    run_to_halt(rv_ctrl_pkg::trap_ebreak, -1, 0);
  endtask

  // path 0 4 16 20 36 24 28 44
  task automatic test_jal();
    reset_core();
    prog.delete();
    emit_addi(1, 0, 1);
    emit_jal(2, 12);
    emit_ebreak();
    emit_ebreak();
    emit_addi(3, 0, 3);
    emit_jal(4, 16);
    emit_addi(5, 0, 5);
    emit_jal(0, 16);
    emit_ebreak();
    emit_jal(6, -12);
    emit_ebreak();
    emit_ebreak();
    load_program();
    run_to_halt(rv_ctrl_pkg::trap_ebreak, -1, 0);
  endtask

  task automatic test_illegal();
    reset_core();
    prog.delete();
    emit_addi(1, 0, 3);
    // slli encoding, outside the subset
    emit_i(rv_isa_pkg::op_imm, 1, 2, 1, 1);
    emit_addi(3, 0, 7);
    load_program();
    run_to_halt(rv_ctrl_pkg::trap_illegal, -1, 0);
  endtask

  task automatic test_stall();
    reset_core();
    prog.delete();
    emit_addi(1, 0, int'(rand_bits(12)));
    emit_random_chain(10);
    emit_ebreak();
    load_program();
    run_to_halt(rv_ctrl_pkg::trap_ebreak, 4, 6);
  endtask

  initial begin
    arst_n    = 1'b0;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    lfsr      = 32'hb4cc_c0b7;
    test_reset_state();
    test_arith();
    test_upper();
    test_jal();
    test_illegal();
    test_stall();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: source/rv_core_top.sv
/*
  rv64 single cycle core
  instruction store, decode, registers, alu and fetch
*/
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_top (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           run,
  input  logic                           load_en,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] load_addr,
  input  logic [`INST_W-1:0]             load_data,
  output logic                           retire_valid,
  output logic [`XLEN-1:0]               retire_pc,
  output logic [`REG_IDX_W-1:0]          retire_rd,
  output logic                           retire_wen,
  output logic [`XLEN-1:0]               retire_data,
  output logic                           halted,
  output rv_ctrl_pkg::trap_e             trap_cause
);

  logic [`XLEN-1:0]      pc;
  logic [`XLEN-1:0]      link_pc;
  logic [`INST_W-1:0]    inst;
  logic [`REG_IDX_W-1:0] rs1;
  logic [`REG_IDX_W-1:0] rs2;
  logic [`REG_IDX_W-1:0] rd;
  logic [`XLEN-1:0]      imm;
  logic                  use_imm;
  logic                  use_pc;
  logic                  reg_wen;
  logic                  is_jal;
  rv_ctrl_pkg::alu_op_e  alu_op;
  rv_ctrl_pkg::trap_e    trap;
  logic [`XLEN-1:0]      rdata_1;
  logic [`XLEN-1:0]      rdata_2;
  logic [`XLEN-1:0]      result;
  logic                  advance;
  logic                  rf_wen;

  // write only when the instruction actually commits
  assign rf_wen = reg_wen && advance;

  inst_mem inst_mem_i (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .inst      (inst)
  );

  inst_decoder inst_decoder_i (
    .inst    (inst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .imm     (imm),
    .use_imm (use_imm),
    .use_pc  (use_pc),
    .reg_wen (reg_wen),
    .is_jal  (is_jal),
    .alu_op  (alu_op),
    .trap    (trap)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .wen     (rf_wen),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .wdata   (result),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  exec_unit exec_unit_i (
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .imm     (imm),
    .pc      (pc),
    .link_pc (link_pc),
    .use_imm (use_imm),
    .use_pc  (use_pc),
    .is_jal  (is_jal),
    .alu_op  (alu_op),
    .result  (result)
  );

  fetch_unit fetch_unit_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .is_jal     (is_jal),
    .imm        (imm),
    .trap       (trap),
    .pc         (pc),
    .link_pc    (link_pc),
    .advance    (advance),
    .halted     (halted),
    .trap_cause (trap_cause)
  );

  // retire port shows the committing instruction
  assign retire_valid = advance;
  assign retire_pc    = pc;
  assign retire_rd    = rd;
  assign retire_wen   = rf_wen;
  assign retire_data  = result;

endmodule

// File: source/fetch_unit.sv
/*
  fetch unit
  pc register, next pc choice and the sticky halt state
*/
`timescale 1ns/100ps
`include "rv_consts.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  run,
  input  logic                  is_jal,
  input  logic [`XLEN-1:0]      imm,
  input  rv_ctrl_pkg::trap_e    trap,
  output logic [`XLEN-1:0]      pc,
  output logic [`XLEN-1:0]      link_pc,
  output logic                  advance,
  output logic                  halted,
  output rv_ctrl_pkg::trap_e    trap_cause
);

  logic [`XLEN-1:0] jal_target;
  logic             active;

  // sequential and jump successors
  assign link_pc    = pc + `XLEN'd4;
  assign jal_target = pc + imm;

  // running and not yet stopped
  assign active = run && !halted;

  // commit only a non trapping instruction
  assign advance = active && (trap == rv_ctrl_pkg::trap_none);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc         <= `RST_PC;
      halted     <= 1'b0;
      trap_cause <= rv_ctrl_pkg::trap_none;
    end else if (advance) begin
      pc <= is_jal ? jal_target : link_pc;
    end else if (active) begin
      // trapping word, pc freezes on it
      halted     <= 1'b1;
      trap_cause <= trap;
    end
  end

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
  ) else $error("pc %h not word aligned", pc);

  // only reset may clear a halt
  a_halt_sticky: assert property (
    @(posedge clk) disable iff (!arst_n) halted |=> halted
  ) else $error("halted dropped without reset");

endmodule

// File: source/exec_unit.sv
/*
  execute unit
  operand muxes and the add, sub, pass alu
*/
`timescale 1ns/100ps
`include "rv_consts.svh"

module exec_unit (
  input  logic [`XLEN-1:0]     rdata_1,
  input  logic [`XLEN-1:0]     rdata_2,
  input  logic [`XLEN-1:0]     imm,
  input  logic [`XLEN-1:0]     pc,
  input  logic [`XLEN-1:0]     link_pc,
  input  logic                 use_imm,
  input  logic                 use_pc,
  input  logic                 is_jal,
  input  rv_ctrl_pkg::alu_op_e alu_op,
  output logic [`XLEN-1:0]     result
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;

  // pc as first operand for auipc and jal
  assign op_a = use_pc ? pc : rdata_1;

  // jal passes pc+4 through as the link value
  assign op_b = is_jal  ? link_pc :
                use_imm ? imm     : rdata_2;

  always_comb begin
    case (alu_op)
      rv_ctrl_pkg::alu_add:    result = op_a + op_b;
      rv_ctrl_pkg::alu_sub:    result = op_a - op_b;
      rv_ctrl_pkg::alu_pass_b: result = op_b;
      default:                 result = op_a + op_b;
    endcase
  end

endmodule

// File: source/reg_file.sv
/*
  integer register file
  two async reads, one clocked write, x0 reads as zero
*/
`timescale 1ns/100ps
`include "rv_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  wen,
  input  logic [`REG_IDX_W-1:0] rd,
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  input  logic [`XLEN-1:0]      wdata,
  output logic [`XLEN-1:0]      rdata_1,
  output logic [`XLEN-1:0]      rdata_2
);

  // entry 0 is kept but never written
  logic [`XLEN-1:0] regs [2**`REG_IDX_W];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**`REG_IDX_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // read ports, x0 forced to zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/inst_decoder.sv
/*
  instruction decoder
  register indices, immediate and control levels, ebreak and illegal detection
*/
`timescale 1ns/100ps
`include "rv_consts.svh"

module inst_decoder (
  input  logic [`INST_W-1:0]    inst,
  output logic [`REG_IDX_W-1:0] rs1,
  output logic [`REG_IDX_W-1:0] rs2,
  output logic [`REG_IDX_W-1:0] rd,
  output logic [`XLEN-1:0]      imm,
  output logic                  use_imm,
  output logic                  use_pc,
  output logic                  reg_wen,
  output logic                  is_jal,
  output rv_ctrl_pkg::alu_op_e  alu_op,
  output rv_ctrl_pkg::trap_e    trap
);

  rv_isa_pkg::inst_u inst_w;
  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_u;
  logic [`XLEN-1:0]  imm_j;
  // instruction has a destination, before the x0 check
  logic              writes_rd;

  assign inst_w = inst;

  // register fields sit in the same place in every format
  assign rs1 = inst_w.r_fmt.rs1;
  assign rs2 = inst_w.r_fmt.rs2;
  assign rd  = inst_w.r_fmt.rd;

  // sign extended immediates
  assign imm_i = {{(`XLEN-12){inst_w.i_fmt.imm12[11]}}, inst_w.i_fmt.imm12};
  assign imm_u = {{(`XLEN-32){inst_w.u_fmt.imm20[19]}}, inst_w.u_fmt.imm20, 12'b0};
  // unscramble j bits back into imm[20:1]
  assign imm_j = {{(`XLEN-20){inst_w.j_fmt.imm20[19]}},
                  inst_w.j_fmt.imm20[7:0],
                  inst_w.j_fmt.imm20[8],
                  inst_w.j_fmt.imm20[18:9],
                  1'b0};

  always_comb begin
    imm       = '0;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    is_jal    = 1'b0;
    writes_rd = 1'b0;
    alu_op    = rv_ctrl_pkg::alu_add;
    trap      = rv_ctrl_pkg::trap_none;
    case (inst_w.r_fmt.opcode)
      rv_isa_pkg::op_imm: begin
        // addi only
        if (inst_w.i_fmt.funct3 == 3'b000) begin
          imm       = imm_i;
          use_imm   = 1'b1;
          writes_rd = 1'b1;
        end else begin
          trap = rv_ctrl_pkg::trap_illegal;
        end
      end
      rv_isa_pkg::op: begin
        if (inst_w.r_fmt.funct3 == 3'b000 && inst_w.r_fmt.funct7 == 7'b0000000) begin
          writes_rd = 1'b1;
        end else if (inst_w.r_fmt.funct3 == 3'b000 &&
                     inst_w.r_fmt.funct7 == 7'b0100000) begin
          alu_op    = rv_ctrl_pkg::alu_sub;
          writes_rd = 1'b1;
        end else begin
          trap = rv_ctrl_pkg::trap_illegal;
        end
      end
      rv_isa_pkg::lui: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        alu_op    = rv_ctrl_pkg::alu_pass_b;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::auipc: begin
        // pc + upper immediate
        imm       = imm_u;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::jal: begin
        // link value passes through the alu, target goes to fetch
        imm       = imm_j;
        use_pc    = 1'b1;
        is_jal    = 1'b1;
        alu_op    = rv_ctrl_pkg::alu_pass_b;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::system: begin
        // ebreak matched on the full word
        if (inst == 32'h0010_0073) begin
          trap = rv_ctrl_pkg::trap_ebreak;
        end else begin
          trap = rv_ctrl_pkg::trap_illegal;
        end
      end
      default: begin
        trap = rv_ctrl_pkg::trap_illegal;
      end
    endcase
  end

  // x0 is never a real write
  assign reg_wen = writes_rd && (rd != '0);

  // a trapping word must not reach the register file
  always_comb begin
    a_no_wen_on_trap: assert (!(reg_wen && trap != rv_ctrl_pkg::trap_none))
      else $error("register write decoded on trapping instruction %h", inst);
  end

endmodule

// File: source/inst_mem.sv
/*
  instruction store
  loaded word by word from outside, read combinationally by pc
*/
`timescale 1ns/100ps
`include "rv_consts.svh"

module inst_mem (
  input  logic                               clk,
  input  logic                               load_en,
  input  logic [$clog2(`IMEM_DEPTH)-1:0]     load_addr,
  input  logic [`INST_W-1:0]                 load_data,
  input  logic [`XLEN-1:0]                   pc,
  output logic [`INST_W-1:0]                 inst
);

  // word storage, contents come only from the load port
  logic [`INST_W-1:0] mem [`IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // byte pc to word index
  assign inst = mem[pc[$clog2(`IMEM_DEPTH)+1:2]];

  // outside a load, the fetch address must fall inside the store
  a_pc_in_range: assert property (
    @(posedge clk) !load_en |-> (pc < (`IMEM_DEPTH * 4))
  ) else $error("fetch pc %h beyond instruction store", pc);

endmodule

// File: source/rv_ctrl_pkg.sv
/*
  rv control package
  alu operations and halt causes
*/
package rv_ctrl_pkg;

  // alu function select
  typedef enum logic [1:0] {
    alu_add    = 2'd0,
    alu_sub    = 2'd1,
    alu_pass_b = 2'd2
  } alu_op_e;

  // why the core stopped
  typedef enum logic [1:0] {
    trap_none    = 2'd0,
    trap_ebreak  = 2'd1,
    trap_illegal = 2'd2
  } trap_e;

endpackage

// File: source/rv_isa_pkg.sv
/*
  rv isa package
  major opcodes and the instruction word views
*/
package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    op     = 7'b0110011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    system = 7'b1110011
  } opcode_e;

  // one 32 bit word, four ways of reading it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
    } i_fmt;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      opcode_e     opcode;
    } u_fmt;
    // imm20 holds imm[20|10:1|11|19:12] from msb down
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      opcode_e     opcode;
    } j_fmt;
  } inst_u;

endpackage

// File: source/rv_consts.svh
/*
  rv64 core constants
  machine widths, reset pc and instruction store depth
*/
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// register and pc width
`define XLEN 64

// register index, 32 registers
`define REG_IDX_W 5

// base instruction word
`define INST_W 32

// first fetch address after reset
`define RST_PC 64'h0

// instruction store words
// fetch index comes from pc bits 9:2
`define IMEM_DEPTH 256

`endif
